// File: axi_rd_chain_top.sv
module axi_rd_chain_top
    import axi_rd_pkg::*;
#(
    parameter int DATA_WIDTH      = 32,
    parameter int ADDR_WIDTH      = 16,
    parameter int NUM_STAGES      = 3,
    parameter int AR_REG_ENABLE   = 1,
    parameter int R_REG_ENABLE    = 1,
    parameter int MAX_OUTSTANDING = 4,
    parameter int ROM_BYTES       = 1024
) (
    input  logic                   clk,
    input  logic                   rst,
    input  axi_id_t                arid,
    input  logic [ADDR_WIDTH-1:0]  araddr,
    input  axi_len_t               arlen,
    input  axi_burst_t             arburst,
    input  logic                   arvalid,
    output logic                   arready,
    output axi_id_t                rid,
    output logic [DATA_WIDTH-1:0]  rdata,
    output axi_resp_t              rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready
);

    // link 0 leaves the limiter, link NUM_STAGES feeds the ROM
    axi_rd_if #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) link [0:NUM_STAGES] ();

    axi_rd_limiter #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING),
        .DATA_WIDTH      (DATA_WIDTH),
        .ADDR_WIDTH      (ADDR_WIDTH)
    ) i_limiter (
        .clk     (clk),
        .rst     (rst),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .dn      (link[0])
    );

    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        axi_register_rd #(
            .AR_REG_ENABLE (AR_REG_ENABLE),
            .R_REG_ENABLE  (R_REG_ENABLE),
            .DATA_WIDTH    (DATA_WIDTH),
            .ADDR_WIDTH    (ADDR_WIDTH)
        ) i_slice (
            .clk (clk),
            .rst (rst),
            .up  (link[k]),
            .dn  (link[k+1])
        );
    end

    axi_rd_pattern_rom #(
        .ROM_BYTES  (ROM_BYTES),
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_rom (
        .clk (clk),
        .rst (rst),
        .up  (link[NUM_STAGES])
    );

endmodule

// File: axi_rd_if.sv
interface axi_rd_if
    import axi_rd_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16
);

    // AR channel
    axi_id_t                arid;
    logic [ADDR_WIDTH-1:0]  araddr;
    axi_len_t               arlen;
    axi_burst_t             arburst;
    logic                   arvalid;
    logic                   arready;

    // R channel
    axi_id_t                rid;
    logic [DATA_WIDTH-1:0]  rdata;
    axi_resp_t              rresp;
    logic                   rlast;
    logic                   rvalid;
    logic                   rready;

    // side that issues requests and takes read data
    modport mgr (
        output arid, araddr, arlen, arburst, arvalid,
        input  arready,
        input  rid, rdata, rresp, rlast, rvalid,
        output rready
    );

    // side that accepts requests and returns read data
    modport sub (
        input  arid, araddr, arlen, arburst, arvalid,
        output arready,
        output rid, rdata, rresp, rlast, rvalid,
        input  rready
    );

endinterface

// File: axi_rd_limiter.sv
module axi_rd_limiter
    import axi_rd_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 4,
    parameter int DATA_WIDTH      = 32,
    parameter int ADDR_WIDTH      = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  axi_id_t                arid,
    input  logic [ADDR_WIDTH-1:0]  araddr,
    input  axi_len_t               arlen,
    input  axi_burst_t             arburst,
    input  logic                   arvalid,
    output logic                   arready,
    output axi_id_t                rid,
    output logic [DATA_WIDTH-1:0]  rdata,
    output axi_resp_t              rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready,
    axi_rd_if.mgr                  dn
);

    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    logic [CNT_W-1:0] count;
    logic             can_issue;
    logic             ar_fire;
    logic             r_done;

    assign can_issue = count < CNT_W'(MAX_OUTSTANDING);

    // AR gated on both sides while the limit is reached
    assign dn.arid    = arid;
    assign dn.araddr  = araddr;
    assign dn.arlen   = arlen;
    assign dn.arburst = arburst;
    assign dn.arvalid = arvalid & can_issue;
    assign arready    = dn.arready & can_issue;

    // R passes straight through
    assign rid       = dn.rid;
    assign rdata     = dn.rdata;
    assign rresp     = dn.rresp;
    assign rlast     = dn.rlast;
    assign rvalid    = dn.rvalid;
    assign dn.rready = rready;

    assign ar_fire = arvalid & arready;
    assign r_done  = dn.rvalid & rready & dn.rlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({ar_fire, r_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a burst can only end after its request passed this point
    a_count_range: assert property (@(posedge clk) disable iff (rst)
        (count <= CNT_W'(MAX_OUTSTANDING)) && !(r_done && !ar_fire && count == '0));

endmodule

// File: axi_rd_pattern_rom.sv
module axi_rd_pattern_rom
    import axi_rd_pkg::*;
#(
    parameter int ROM_BYTES  = 1024,
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16
) (
    input  logic   clk,
    input  logic   rst,
    axi_rd_if.sub  up
);

    typedef enum logic {
        ROM_IDLE,
        ROM_BURST
    } rom_state_t;

    rom_state_t             state;
    axi_len_t               beat;
    logic                   ar_fire;
    logic                   r_fire;
    logic                   last_beat;
    logic                   in_range;

    // request fields held for the whole burst
    axi_id_t                id_reg;
    axi_len_t               len_reg;
    axi_burst_t             burst_reg;
    logic [ADDR_WIDTH-1:0]  beat_addr;

    assign up.arready = (state == ROM_IDLE);
    assign up.rvalid  = (state == ROM_BURST);

    assign ar_fire   = up.arvalid & up.arready;
    assign r_fire    = up.rvalid & up.rready;
    assign last_beat = (beat == len_reg);
    assign in_range  = 32'(beat_addr) < ROM_BYTES;

    // beats past the end of the ROM answer with an error and no data
    assign up.rid   = id_reg;
    assign up.rlast = last_beat;
    assign up.rresp = in_range ? RESP_OKAY : RESP_SLVERR;
    assign up.rdata = in_range ? DATA_WIDTH'(pattern_word(32'(beat_addr))) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ROM_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                ROM_IDLE: begin
                    if (ar_fire) begin
                        state <= ROM_BURST;
                        beat  <= '0;
                    end
                end
                ROM_BURST: begin
                    if (r_fire) begin
                        if (last_beat) begin
                            state <= ROM_IDLE;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                default: state <= ROM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_reg    <= up.arid;
            len_reg   <= up.arlen;
            burst_reg <= up.arburst;
            beat_addr <= up.araddr;
        end else if (r_fire && !last_beat && burst_reg != BURST_FIXED) begin
            // INCR and WRAP both step one word
            beat_addr <= beat_addr + ADDR_WIDTH'(4);
        end
    end

    // beat held unchanged until the chain takes it
    a_r_stable: assert property (@(posedge clk) disable iff (rst)
        (up.rvalid && !up.rready) |=>
            (up.rvalid && $stable({up.rid, up.rdata, up.rresp, up.rlast})));

endmodule

// File: axi_rd_pkg.sv
package axi_rd_pkg;

    // AXI read field types
    typedef logic [3:0] axi_id_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;

    // burst type codes, WRAP is served as INCR
    localparam axi_burst_t BURST_FIXED = 2'b00;
    localparam axi_burst_t BURST_INCR  = 2'b01;

    // response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // seed mixed into every ROM word
    localparam logic [31:0] PATTERN_KEY = 32'h5a3c_96e1;

    // ROM content for a byte address, one word per 4 bytes
    function automatic logic [31:0] pattern_word(input logic [31:0] byte_addr);
        logic [31:0] word_index;
        word_index = byte_addr >> 2;
        return word_index ^ PATTERN_KEY;
    endfunction

endpackage

// File: axi_register_rd.sv
module axi_register_rd
    import axi_rd_pkg::*;
#(
    parameter int AR_REG_ENABLE = 1,
    parameter int R_REG_ENABLE  = 1,
    parameter int DATA_WIDTH    = 32,
    parameter int ADDR_WIDTH    = 16
) (
    input  logic     clk,
    input  logic     rst,
    axi_rd_if.sub    up,
    axi_rd_if.mgr    dn
);

    // flattened payload widths per channel
    localparam int AR_W = $bits(axi_id_t) + ADDR_WIDTH + $bits(axi_len_t) + $bits(axi_burst_t);
    localparam int R_W  = $bits(axi_id_t) + DATA_WIDTH + $bits(axi_resp_t) + 1;

    if (AR_REG_ENABLE != 0) begin : g_ar_reg
        logic [AR_W-1:0] ar_in;
        logic [AR_W-1:0] ar_out_reg;
        logic [AR_W-1:0] ar_temp_reg;
        logic            ar_out_valid;
        logic            ar_out_valid_next;
        logic            ar_temp_valid;
        logic            ar_temp_valid_next;
        logic            ar_ready_reg;
        logic            ar_ready_early;
        logic            ar_in_to_out;
        logic            ar_in_to_temp;
        logic            ar_temp_to_out;

        assign ar_in = {up.arid, up.araddr, up.arlen, up.arburst};
        assign {dn.arid, dn.araddr, dn.arlen, dn.arburst} = ar_out_reg;
        assign dn.arvalid = ar_out_valid;
        assign up.arready = ar_ready_reg;

        // accept next cycle unless the skid register would fill
        assign ar_ready_early = dn.arready | (~ar_temp_valid & (~ar_out_valid | ~up.arvalid));

        always_comb begin
            ar_out_valid_next  = ar_out_valid;
            ar_temp_valid_next = ar_temp_valid;
            ar_in_to_out       = 1'b0;
            ar_in_to_temp      = 1'b0;
            ar_temp_to_out     = 1'b0;
            if (ar_ready_reg) begin
                if (dn.arready | ~ar_out_valid) begin
                    ar_out_valid_next = up.arvalid;
                    ar_in_to_out      = 1'b1;
                end else begin
                    // output stalled, park the input
                    ar_temp_valid_next = up.arvalid;
                    ar_in_to_temp      = 1'b1;
                end
            end else if (dn.arready) begin
                ar_out_valid_next  = ar_temp_valid;
                ar_temp_valid_next = 1'b0;
                ar_temp_to_out     = 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                ar_ready_reg  <= 1'b0;
                ar_out_valid  <= 1'b0;
                ar_temp_valid <= 1'b0;
            end else begin
                ar_ready_reg  <= ar_ready_early;
                ar_out_valid  <= ar_out_valid_next;
                ar_temp_valid <= ar_temp_valid_next;
            end
        end

        always_ff @(posedge clk) begin
            if (ar_in_to_out) begin
                ar_out_reg <= ar_in;
            end else if (ar_temp_to_out) begin
                ar_out_reg <= ar_temp_reg;
            end
            if (ar_in_to_temp) begin
                ar_temp_reg <= ar_in;
            end
        end

        // registered ready must drop before a second item reaches the skid register
        a_ar_temp_no_overwrite: assert property (@(posedge clk) disable iff (rst)
            (ar_in_to_temp && up.arvalid) |-> !ar_temp_valid);
    end else begin : g_ar_bypass
        assign dn.arid    = up.arid;
        assign dn.araddr  = up.araddr;
        assign dn.arlen   = up.arlen;
        assign dn.arburst = up.arburst;
        assign dn.arvalid = up.arvalid;
        assign up.arready = dn.arready;
    end

    if (R_REG_ENABLE != 0) begin : g_r_reg
        logic [R_W-1:0] r_in;
        logic [R_W-1:0] r_out_reg;
        logic [R_W-1:0] r_temp_reg;
        logic           r_out_valid;
        logic           r_out_valid_next;
        logic           r_temp_valid;
        logic           r_temp_valid_next;
        logic           r_ready_reg;
        logic           r_ready_early;
        logic           r_in_to_out;
        logic           r_in_to_temp;
        logic           r_temp_to_out;

        // read data flows from dn back to up
        assign r_in = {dn.rid, dn.rdata, dn.rresp, dn.rlast};
        assign {up.rid, up.rdata, up.rresp, up.rlast} = r_out_reg;
        assign up.rvalid = r_out_valid;
        assign dn.rready = r_ready_reg;

        assign r_ready_early = up.rready | (~r_temp_valid & (~r_out_valid | ~dn.rvalid));

        always_comb begin
            r_out_valid_next  = r_out_valid;
            r_temp_valid_next = r_temp_valid;
            r_in_to_out       = 1'b0;
            r_in_to_temp      = 1'b0;
            r_temp_to_out     = 1'b0;
            if (r_ready_reg) begin
                if (up.rready | ~r_out_valid) begin
                    r_out_valid_next = dn.rvalid;
                    r_in_to_out      = 1'b1;
                end else begin
                    r_temp_valid_next = dn.rvalid;
                    r_in_to_temp      = 1'b1;
                end
            end else if (up.rready) begin
                r_out_valid_next  = r_temp_valid;
                r_temp_valid_next = 1'b0;
                r_temp_to_out     = 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                r_ready_reg  <= 1'b0;
                r_out_valid  <= 1'b0;
                r_temp_valid <= 1'b0;
            end else begin
                r_ready_reg  <= r_ready_early;
                r_out_valid  <= r_out_valid_next;
                r_temp_valid <= r_temp_valid_next;
            end
        end

        always_ff @(posedge clk) begin
            if (r_in_to_out) begin
                r_out_reg <= r_in;
            end else if (r_temp_to_out) begin
                r_out_reg <= r_temp_reg;
            end
            if (r_in_to_temp) begin
                r_temp_reg <= r_in;
            end
        end

        a_r_temp_no_overwrite: assert property (@(posedge clk) disable iff (rst)
            (r_in_to_temp && dn.rvalid) |-> !r_temp_valid);
    end else begin : g_r_bypass
        assign up.rid    = dn.rid;
        assign up.rdata  = dn.rdata;
        assign up.rresp  = dn.rresp;
        assign up.rlast  = dn.rlast;
        assign up.rvalid = dn.rvalid;
        assign dn.rready = up.rready;
    end

endmodule

// File: src.f
axi_rd_pkg.sv
axi_rd_if.sv
axi_register_rd.sv
axi_rd_limiter.sv
axi_rd_pattern_rom.sv
axi_rd_chain_top.sv
tb_axi_rd_chain.sv

// File: tb_axi_rd_chain.sv
module tb_axi_rd_chain;
    import axi_rd_pkg::*;

    localparam int MAX_OUTSTANDING = 4;
    localparam int ROM_BYTES       = 1024;
    localparam int ACCEPT_TIMEOUT  = 1000;
    localparam int DRAIN_TIMEOUT   = 5000;

    typedef struct packed {
        axi_id_t    id;
        logic [15:0] addr;
        axi_len_t   len;
        axi_burst_t burst;
        logic [3:0] gap;
    } req_t;

    typedef struct packed {
        axi_id_t     id;
        logic [31:0] data;
        axi_resp_t   resp;
        logic        last;
    } beat_t;

    logic        clk = 1'b0;
    logic        rst;
    axi_id_t     arid;
    logic [15:0] araddr;
    axi_len_t    arlen;
    axi_burst_t  arburst;
    logic        arvalid;
    logic        arready;
    axi_id_t     rid;
    logic [31:0] rdata;
    axi_resp_t   rresp;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic        stall_r;

    req_t  req_q[$];
    beat_t exp_q[$];
    beat_t exp_front;
    logic  exp_valid;
    int    outstanding;

    always #10 clk = ~clk;

    axi_rd_chain_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // expected beats built from each accepted request, front registered for the checks
    always @(posedge clk) begin
        logic [15:0] addr;
        beat_t       beat;
        if (rst) begin
            exp_q.delete();
            outstanding <= 0;
            exp_valid   <= 1'b0;
        end else begin
            if (rvalid && rready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (arvalid && arready) begin
                addr = araddr;
                for (int i = 0; i <= int'(arlen); i++) begin
                    beat.id   = arid;
                    beat.last = (i == int'(arlen));
                    beat.resp = (32'(addr) < ROM_BYTES) ? RESP_OKAY : RESP_SLVERR;
                    beat.data = (32'(addr) < ROM_BYTES) ? pattern_word(32'(addr)) : '0;
                    exp_q.push_back(beat);
                    // FIXED keeps the address, INCR and WRAP step one word
                    if (arburst != BURST_FIXED) begin
                        addr = addr + 16'd4;
                    end
                end
            end
            outstanding <= outstanding + int'(arvalid && arready)
                - int'(rvalid && rready && rlast);
            exp_valid <= (exp_q.size() > 0);
            if (exp_q.size() > 0) begin
                exp_front <= exp_q[0];
            end
        end
    end

    a_beat_expected: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rready) |-> exp_valid)
        else begin
            $display("read beat at %0t arrived with no request left to answer", $time);
            abort_run();
        end

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rready && exp_valid) |-> (rdata == exp_front.data))
        else begin
            $display("mismatch at %0t: rdata got %h expected %h", $time,
                $sampled(rdata), $sampled(exp_front.data));
            abort_run();
        end

    a_rresp: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rready && exp_valid) |-> (rresp == exp_front.resp))
        else begin
            $display("mismatch at %0t: rresp got %h expected %h", $time,
                $sampled(rresp), $sampled(exp_front.resp));
            abort_run();
        end

    a_rlast: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rready && exp_valid) |-> (rlast == exp_front.last))
        else begin
            $display("mismatch at %0t: rlast got %b expected %b", $time,
                $sampled(rlast), $sampled(exp_front.last));
            abort_run();
        end

    a_rid: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rready && exp_valid) |-> (rid == exp_front.id))
        else begin
            $display("mismatch at %0t: rid got %h expected %h", $time,
                $sampled(rid), $sampled(exp_front.id));
            abort_run();
        end

    a_outstanding: assert property (@(posedge clk) disable iff (rst)
        outstanding <= MAX_OUTSTANDING)
        else begin
            $display("more than %0d bursts in flight at the top-level ports", MAX_OUTSTANDING);
            abort_run();
        end

    task automatic queue_read(input axi_id_t id, input logic [15:0] addr, input axi_len_t len,
                              input axi_burst_t burst, input logic [3:0] gap);
        req_t req;
        req.id    = id;
        req.addr  = addr;
        req.len   = len;
        req.burst = burst;
        req.gap   = gap;
        req_q.push_back(req);
    endtask

    // request stays at the queue front until its handshake
    task automatic issue_requests();
        req_t req;
        int   waited;
        forever begin
            if (req_q.size() == 0) begin
                @(posedge clk);
                #1;
            end else begin
                req = req_q[0];
                repeat (req.gap) begin
                    @(posedge clk);
                    #1;
                end
                arid    = req.id;
                araddr  = req.addr;
                arlen   = req.len;
                arburst = req.burst;
                arvalid = 1'b1;
                waited  = 0;
                @(negedge clk);
                while (!arready) begin
                    if (waited >= ACCEPT_TIMEOUT) begin
                        $display("request to address %h was not accepted in time", req.addr);
                        abort_run();
                    end else begin
                        waited++;
                        @(negedge clk);
                    end
                end
                @(posedge clk);
                #1;
                arvalid = 1'b0;
                void'(req_q.pop_front());
            end
        end
    endtask

    task automatic pace_rready();
        forever begin
            @(posedge clk);
            #1;
            rready = stall_r ? 1'b0 : ($urandom_range(0, 99) < 70);
        end
    endtask

    task automatic drain_all(input string what);
        int cycles;
        cycles = 0;
        while (req_q.size() != 0 || exp_q.size() != 0 || outstanding != 0) begin
            if (cycles >= DRAIN_TIMEOUT) begin
                $display("%s did not complete within %0d cycles", what, DRAIN_TIMEOUT);
                abort_run();
            end else begin
                cycles++;
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic fill_to_limit();
        int cycles;
        cycles = 0;
        while (outstanding != MAX_OUTSTANDING) begin
            if (cycles >= DRAIN_TIMEOUT) begin
                $display("outstanding bursts never reached the limit while stalled");
                abort_run();
            end else begin
                cycles++;
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial begin
        axi_burst_t burst;
        void'($urandom(40));
        rst     = 1'b1;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arburst = BURST_INCR;
        arvalid = 1'b0;
        rready  = 1'b0;
        stall_r = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            issue_requests();
            pace_rready();
        join_none

        queue_read(4'h1, 16'h0040, 8'd0, BURST_INCR, 4'd0);
        drain_all("single-beat read");

        for (int i = 0; i < 12; i++) begin
            queue_read(axi_id_t'(i), 16'($urandom_range(0, 180) * 4),
                axi_len_t'($urandom_range(0, 15)), BURST_INCR, 4'd0);
        end
        drain_all("INCR bursts");

        queue_read(4'h7, 16'h0100, 8'd5, BURST_FIXED, 4'd0);
        drain_all("FIXED burst");

        // past the end, then a burst that crosses it
        queue_read(4'h9, 16'h0400, 8'd2, BURST_INCR, 4'd0);
        queue_read(4'ha, 16'h03f0, 8'd7, BURST_INCR, 4'd1);
        drain_all("out-of-range bursts");

        for (int i = 0; i < 30; i++) begin
            burst = ($urandom_range(0, 3) == 0) ? BURST_FIXED : BURST_INCR;
            queue_read(axi_id_t'($urandom), 16'($urandom_range(0, 280) * 4),
                axi_len_t'($urandom_range(0, 15)), burst, 4'($urandom_range(0, 3)));
        end
        drain_all("random traffic");

        // R held off so requests pile up against the limiter
        stall_r = 1'b1;
        for (int i = 0; i < 8; i++) begin
            queue_read(axi_id_t'(i), 16'(i * 16), 8'd1, BURST_INCR, 4'd0);
        end
        fill_to_limit();
        repeat (20) @(posedge clk);
        #1;
        stall_r = 1'b0;
        drain_all("stalled requests");

        if (req_q.size() == 0 && exp_q.size() == 0 && outstanding == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("requests or expected beats were left over at the end");
            abort_run();
        end
    end

endmodule
